/* hw/platform_cfg.svh */
// platform configuration
// fixed address map and slave count for the peripheral bus,
// plus the uart bit timing and mtimer tick rate
// every slave decodes a 4 KiB window under SLAVE_MASK

`ifndef PLATFORM_CFG_SVH
`define PLATFORM_CFG_SVH

// slaves behind the decoder
`define NUM_SLAVES 3

// base addresses, one 4 KiB page each
`define MTIMER_BASE 32'h0002_0000
`define LED_BASE    32'h0002_1000
`define UART_BASE   32'h0002_2000
`define SLAVE_MASK  32'hFFFF_F000

// clk cycles per uart bit
`define UART_BAUD_DIV 16
// clk cycles per mtime tick
`define MTIMER_PRESCALE 1

`endif

/* hw/bus_pkg.sv */
// bus package
// pipelined wishbone request/response bundles and the
// slave select code produced by the address decoder

`default_nettype none

package bus_pkg;

    // master -> slave
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  sel;
    } wb_req_t;

    // slave -> master
    typedef struct packed {
        logic        ack;
        logic        err;
        logic        stall;
        logic [31:0] rdata;
    } wb_rsp_t;

    // decoder target, values double as slave port index
    typedef enum logic [1:0] {
        SEL_MTIMER = 2'd0,
        SEL_LED    = 2'd1,
        SEL_UART   = 2'd2,
        SEL_NONE   = 2'd3
    } slave_sel_e;

endpackage : bus_pkg

`default_nettype wire

/* hw/platform_pkg.sv */
// platform package
// register word offsets of each peripheral (addr[3:2])
// and the uart transmitter states

`default_nettype none

package platform_pkg;

    // mtimer, 64-bit regs split into words
    typedef enum logic [1:0] {
        MTIME_LO    = 2'd0,
        MTIME_HI    = 2'd1,
        MTIMECMP_LO = 2'd2,
        MTIMECMP_HI = 2'd3
    } mtimer_reg_e;

    // led driver, offset picks the update op
    typedef enum logic [1:0] {
        LED_WRITE  = 2'd0,
        LED_SET    = 2'd1,
        LED_CLEAR  = 2'd2,
        LED_TOGGLE = 2'd3
    } led_reg_e;

    // uart, offsets 2 and 3 unused
    typedef enum logic [1:0] {
        UART_TXDATA = 2'd0,
        UART_STATUS = 2'd1
    } uart_reg_e;

    typedef enum logic [1:0] {
        IDLE,
        START,
        DATA,
        STOP
    } uart_state_e;

endpackage : platform_pkg

`default_nettype wire

/* hw/wb_decoder.sv */
// wishbone address decoder
// single master to NUM_SLAVES slaves, stb steered by address,
// responses routed back from the slave accepted one cycle earlier
// unmapped addresses are answered here with err

`timescale 1ns/1ps
`include "platform_cfg.svh"
`default_nettype none

module wb_decoder (
    input  wire logic       clk_i,
    input  wire logic       rst_n_i,

    // master side
    input  bus_pkg::wb_req_t m_req_i,
    output bus_pkg::wb_rsp_t m_rsp_o,

    // slave side
    output bus_pkg::wb_req_t s_req_o [`NUM_SLAVES],
    input  bus_pkg::wb_rsp_t s_rsp_i [`NUM_SLAVES]
);
    import bus_pkg::*;

    slave_sel_e sel;
    slave_sel_e pend_sel;
    logic       pend_valid;
    logic       accept;

    // address match under the page mask
    always_comb begin
        sel = SEL_NONE;
        if ((m_req_i.addr & `SLAVE_MASK) == `MTIMER_BASE) begin
            sel = SEL_MTIMER;
        end else if ((m_req_i.addr & `SLAVE_MASK) == `LED_BASE) begin
            sel = SEL_LED;
        end else if ((m_req_i.addr & `SLAVE_MASK) == `UART_BASE) begin
            sel = SEL_UART;
        end
    end

    // cyc and payload go everywhere, stb only to the target
    always_comb begin
        for (int i = 0; i < `NUM_SLAVES; i++) begin
            s_req_o[i]     = m_req_i;
            s_req_o[i].stb = m_req_i.stb && (sel == slave_sel_e'(i));
        end
    end

    // stall comes straight from the addressed slave
    // response side muxed by the registered select
    always_comb begin
        m_rsp_o = '0;
        for (int i = 0; i < `NUM_SLAVES; i++) begin
            if (sel == slave_sel_e'(i)) begin
                m_rsp_o.stall = s_rsp_i[i].stall;
            end
            if (pend_valid && pend_sel == slave_sel_e'(i)) begin
                m_rsp_o.ack   = s_rsp_i[i].ack;
                m_rsp_o.err   = s_rsp_i[i].err;
                m_rsp_o.rdata = s_rsp_i[i].rdata;
            end
        end
        // unmapped, rdata stays zero
        if (pend_valid && pend_sel == SEL_NONE) begin
            m_rsp_o.err = 1'b1;
        end
    end

    assign accept = m_req_i.cyc && m_req_i.stb && !m_rsp_o.stall;

    // one transfer in flight per cycle, fixed 1-cycle slave latency
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            pend_valid <= 1'b0;
            pend_sel   <= SEL_NONE;
        end else begin
            pend_valid <= accept;
            pend_sel   <= sel;
        end
    end

    // a slave may only answer the transfer the decoder handed it
    for (genvar gi = 0; gi < `NUM_SLAVES; gi++) begin : g_ack_chk
        a_no_stray_ack: assert property (@(posedge clk_i) disable iff (!rst_n_i)
            s_rsp_i[gi].ack |-> (pend_valid && pend_sel == slave_sel_e'(gi)))
            else $error("slave %0d acked without a pending request", gi);
    end

endmodule : wb_decoder

`default_nettype wire

/* hw/mtimer.sv */
// machine timer
// 64-bit mtime counting every MTIMER_PRESCALE cycles, 64-bit mtimecmp,
// both word-accessible with byte selects
// timer_irq_o is a registered mtime >= mtimecmp level

`timescale 1ns/1ps
`include "platform_cfg.svh"
`default_nettype none

module mtimer (
    input  wire logic        clk_i,
    input  wire logic        rst_n_i,

    input  bus_pkg::wb_req_t req_i,
    output bus_pkg::wb_rsp_t rsp_o,

    output logic             timer_irq_o
);
    import platform_pkg::*;

    logic [63:0] mtime;
    logic [63:0] mtimecmp;
    logic [15:0] presc_cnt;
    logic        tick;
    logic        accept;
    logic        wr;
    logic        mtime_wr;
    mtimer_reg_e reg_sel;
    logic        ack_q;
    logic [31:0] rdata_q;

    // keep old bytes where sel is clear
    function automatic logic [31:0] byte_merge(input logic [31:0] old_w,
                                               input logic [31:0] new_w,
                                               input logic [3:0]  be);
        logic [31:0] res;
        res = old_w;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) res[b*8 +: 8] = new_w[b*8 +: 8];
        end
        return res;
    endfunction

    // never stalls
    assign accept   = req_i.cyc && req_i.stb;
    assign wr       = accept && req_i.we;
    assign reg_sel  = mtimer_reg_e'(req_i.addr[3:2]);
    assign mtime_wr = wr && (reg_sel == MTIME_LO || reg_sel == MTIME_HI);
    assign tick     = (presc_cnt == 16'(`MTIMER_PRESCALE - 1));

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            presc_cnt <= '0;
            mtime     <= '0;
            mtimecmp  <= '1;
        end else begin
            presc_cnt <= tick ? '0 : presc_cnt + 16'd1;
            // bus write wins over the tick
            if (mtime_wr) begin
                if (reg_sel == MTIME_LO) begin
                    mtime[31:0] <= byte_merge(mtime[31:0], req_i.wdata, req_i.sel);
                end else begin
                    mtime[63:32] <= byte_merge(mtime[63:32], req_i.wdata, req_i.sel);
                end
            end else if (tick) begin
                mtime <= mtime + 64'd1;
            end
            if (wr && reg_sel == MTIMECMP_LO) begin
                mtimecmp[31:0] <= byte_merge(mtimecmp[31:0], req_i.wdata, req_i.sel);
            end
            if (wr && reg_sel == MTIMECMP_HI) begin
                mtimecmp[63:32] <= byte_merge(mtimecmp[63:32], req_i.wdata, req_i.sel);
            end
        end
    end

    // irq lags the compare by one cycle
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            timer_irq_o <= 1'b0;
        end else begin
            timer_irq_o <= (mtime >= mtimecmp);
        end
    end

    // bus response
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= accept;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            unique case (reg_sel)
                MTIME_LO:    rdata_q <= mtime[31:0];
                MTIME_HI:    rdata_q <= mtime[63:32];
                MTIMECMP_LO: rdata_q <= mtimecmp[31:0];
                MTIMECMP_HI: rdata_q <= mtimecmp[63:32];
            endcase
        end
    end

    assign rsp_o = '{ack: ack_q, err: 1'b0, stall: 1'b0, rdata: rdata_q};

    // pending interrupt is never missed for more than a cycle
    a_irq_follows: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (!timer_irq_o && mtime >= mtimecmp) |=> timer_irq_o)
        else $error("timer irq low while mtime >= mtimecmp");

endmodule : mtimer

`default_nettype wire

/* hw/led_driver.sv */
// led driver
// 8-bit led register updated by write, set, clear or toggle
// depending on the word offset, data from wdata byte 0

`timescale 1ns/1ps
`default_nettype none

module led_driver (
    input  wire logic        clk_i,
    input  wire logic        rst_n_i,

    input  bus_pkg::wb_req_t req_i,
    output bus_pkg::wb_rsp_t rsp_o,

    output logic [7:0]       led_status_o
);
    import platform_pkg::*;

    logic        accept;
    led_reg_e    op;
    logic        ack_q;
    logic [31:0] rdata_q;

    assign accept = req_i.cyc && req_i.stb;
    assign op     = led_reg_e'(req_i.addr[3:2]);

    // leds change on the same edge that raises ack
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            led_status_o <= '0;
            ack_q        <= 1'b0;
        end else begin
            ack_q <= accept;
            // byte 0 only
            if (accept && req_i.we && req_i.sel[0]) begin
                unique case (op)
                    LED_WRITE:  led_status_o <= req_i.wdata[7:0];
                    LED_SET:    led_status_o <= led_status_o | req_i.wdata[7:0];
                    LED_CLEAR:  led_status_o <= led_status_o & ~req_i.wdata[7:0];
                    LED_TOGGLE: led_status_o <= led_status_o ^ req_i.wdata[7:0];
                endcase
            end
        end
    end

    // any offset reads back the register
    always_ff @(posedge clk_i) begin
        if (accept) rdata_q <= {24'b0, led_status_o};
    end

    assign rsp_o = '{ack: ack_q, err: 1'b0, stall: 1'b0, rdata: rdata_q};

endmodule : led_driver

`default_nettype wire

/* hw/uart_tx.sv */
// uart transmitter
// 8N1 frames at UART_BAUD_DIV clocks per bit, LSB first
// TXDATA write starts a frame, STATUS bit 0 is busy
// TXDATA writes stall while a frame is on the line

`timescale 1ns/1ps
`include "platform_cfg.svh"
`default_nettype none

module uart_tx (
    input  wire logic        clk_i,
    input  wire logic        rst_n_i,

    input  bus_pkg::wb_req_t req_i,
    output bus_pkg::wb_rsp_t rsp_o,

    output logic             uart_tx_o
);
    import platform_pkg::*;

    localparam int BAUD_W = $clog2(`UART_BAUD_DIV);

    uart_state_e       state;
    uart_reg_e         reg_sel;
    logic [BAUD_W-1:0] baud_cnt;
    logic [2:0]        bit_cnt;
    logic [7:0]        shift_q;
    logic              busy;
    logic              bit_end;
    logic              stall;
    logic              accept;
    logic              tx_wr;
    logic              ack_q;
    logic [31:0]       rdata_q;

    assign reg_sel = uart_reg_e'(req_i.addr[3:2]);
    assign busy    = (state != IDLE);
    assign bit_end = (baud_cnt == BAUD_W'(`UART_BAUD_DIV - 1));

    // only TXDATA writes are held off
    assign stall  = req_i.cyc && req_i.stb && req_i.we && reg_sel == UART_TXDATA && busy;
    assign accept = req_i.cyc && req_i.stb && !stall;
    assign tx_wr  = accept && req_i.we && reg_sel == UART_TXDATA && req_i.sel[0];

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state     <= IDLE;
            baud_cnt  <= '0;
            bit_cnt   <= '0;
            uart_tx_o <= 1'b1;
        end else begin
            baud_cnt <= bit_end ? '0 : baud_cnt + 1'b1;
            unique case (state)
                IDLE: begin
                    baud_cnt <= '0;
                    // start bit goes out the cycle after acceptance
                    if (tx_wr) begin
                        state     <= START;
                        uart_tx_o <= 1'b0;
                    end
                end
                START: begin
                    if (bit_end) begin
                        state     <= DATA;
                        bit_cnt   <= '0;
                        uart_tx_o <= shift_q[0];
                    end
                end
                DATA: begin
                    if (bit_end) begin
                        bit_cnt <= bit_cnt + 3'd1;
                        if (bit_cnt == 3'd7) begin
                            state     <= STOP;
                            uart_tx_o <= 1'b1;
                        end else begin
                            uart_tx_o <= shift_q[0];
                        end
                    end
                end
                STOP: begin
                    if (bit_end) state <= IDLE;
                end
            endcase
        end
    end

    // byte latch, shifted at each bit boundary after the start bit
    always_ff @(posedge clk_i) begin
        if (tx_wr) begin
            shift_q <= req_i.wdata[7:0];
        end else if (bit_end && (state == START || state == DATA)) begin
            shift_q <= shift_q >> 1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= accept;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) rdata_q <= (reg_sel == UART_STATUS) ? {31'b0, busy} : 32'b0;
    end

    assign rsp_o = '{ack: ack_q, err: 1'b0, stall: stall, rdata: rdata_q};

    // line idles high between frames
    a_idle_high: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (state == IDLE) |-> uart_tx_o)
        else $error("uart line low while idle");

endmodule : uart_tx

`default_nettype wire

/* hw/yarc_platform.sv */
// peripheral platform top
// bus master port into the address decoder, which feeds
// the machine timer, the led driver and the uart transmitter

`timescale 1ns/1ps
`include "platform_cfg.svh"
`default_nettype none

module yarc_platform (
    input  wire logic        clk_i,
    input  wire logic        rst_n_i,

    // core load/store port
    input  bus_pkg::wb_req_t bus_req_i,
    output bus_pkg::wb_rsp_t bus_rsp_o,

    output logic [7:0]       led_status_o,
    output logic             uart_tx_o,
    output logic             timer_irq_o
);
    import bus_pkg::*;

    // decoder <-> slaves, indexed by slave_sel_e
    wb_req_t s_req [`NUM_SLAVES];
    wb_rsp_t s_rsp [`NUM_SLAVES];

    wb_decoder decoder_i (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .m_req_i (bus_req_i),
        .m_rsp_o (bus_rsp_o),
        .s_req_o (s_req),
        .s_rsp_i (s_rsp)
    );

    // timer irq goes straight out to the core
    mtimer mtimer_i (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .req_i       (s_req[SEL_MTIMER]),
        .rsp_o       (s_rsp[SEL_MTIMER]),
        .timer_irq_o (timer_irq_o)
    );

    led_driver led_driver_i (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .req_i        (s_req[SEL_LED]),
        .rsp_o        (s_rsp[SEL_LED]),
        .led_status_o (led_status_o)
    );

    // tx only, no receive path
    uart_tx uart_tx_i (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .req_i     (s_req[SEL_UART]),
        .rsp_o     (s_rsp[SEL_UART]),
        .uart_tx_o (uart_tx_o)
    );

endmodule : yarc_platform

`default_nettype wire

/* tb/tb_platform.sv */
// platform testbench
// plays the core load/store unit on the bus port, checks responses
// against a queue of expected results, models leds, mtime and the irq,
// and decodes uart frames from the tx line

`timescale 1ns/1ps
`include "platform_cfg.svh"
`default_nettype none

module tb_platform;
    import bus_pkg::*;

    logic        clk_i;
    logic        rst_n_i;
    wb_req_t     bus_req;
    wb_rsp_t     bus_rsp;
    logic [7:0]  led_status;
    logic        uart_tx;
    logic        timer_irq;

    integer      seed;
    integer      err_cnt;
    // expected response entries {err, check data, data}
    logic [33:0] exp_q [$];
    logic [7:0]  uart_exp_q [$];
    logic        acc_q;
    logic        rsp_stray;
    logic        kind_bad;
    logic        err_got;
    logic        err_exp;
    logic        data_bad;
    logic [31:0] data_got;
    logic [31:0] data_exp;
    logic [31:0] last_rdata;
    logic [7:0]  led_model;
    logic [63:0] tick_cnt;
    logic [63:0] cmp_model;
    logic        irq_exp_q;
    logic        frame_done;
    logic        frame_start_ok;
    logic        frame_stop_ok;
    logic        frame_stray;
    logic [7:0]  frame_got;
    logic [7:0]  frame_exp;
    integer      frame_cnt;

    yarc_platform dut (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .bus_req_i    (bus_req),
        .bus_rsp_o    (bus_rsp),
        .led_status_o (led_status),
        .uart_tx_o    (uart_tx),
        .timer_irq_o  (timer_irq)
    );

    always #50 clk_i = ~clk_i;

    // mtime reference, one tick per cycle out of reset
    // irq reference is the registered compare of the two models
    always @(posedge clk_i) begin
        acc_q <= rst_n_i && bus_req.cyc && bus_req.stb && !bus_rsp.stall;
        if (!rst_n_i) begin
            tick_cnt  <= '0;
            irq_exp_q <= 1'b0;
        end else begin
            tick_cnt  <= tick_cnt + 64'd1;
            irq_exp_q <= (tick_cnt >= cmp_model);
        end
    end

    // response scoreboard, sampled mid cycle
    always @(negedge clk_i) begin
        rsp_stray = 1'b0;
        kind_bad  = 1'b0;
        data_bad  = 1'b0;
        if (rst_n_i && (bus_rsp.ack || bus_rsp.err)) begin
            if (exp_q.size() == 0) begin
                rsp_stray = 1'b1;
            end else begin
                data_exp   = exp_q[0][31:0];
                data_got   = bus_rsp.rdata;
                last_rdata = bus_rsp.rdata;
                err_got    = bus_rsp.err;
                err_exp    = exp_q[0][33];
                kind_bad   = (err_got != err_exp);
                data_bad   = exp_q[0][32] && (data_got != data_exp);
                void'(exp_q.pop_front());
            end
        end
    end

    // uart line decoder, samples each bit in its middle
    always begin
        @(negedge clk_i);
        if (rst_n_i && !uart_tx) begin
            repeat (`UART_BAUD_DIV / 2) @(negedge clk_i);
            frame_start_ok = !uart_tx;
            for (int i = 0; i < 8; i++) begin
                repeat (`UART_BAUD_DIV) @(negedge clk_i);
                frame_got[i] = uart_tx;
            end
            repeat (`UART_BAUD_DIV) @(negedge clk_i);
            frame_stop_ok = uart_tx;
            frame_stray   = (uart_exp_q.size() == 0);
            frame_exp     = frame_stray ? 8'h00 : uart_exp_q.pop_front();
            frame_done    = 1'b1;
            frame_cnt     = frame_cnt + 1;
            @(negedge clk_i);
            frame_done = 1'b0;
        end
    end

    // every accepted transfer answered exactly one cycle later
    a_rsp_timing: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        acc_q |-> (bus_rsp.ack ^ bus_rsp.err))
        else begin
            $display("%0t: no single ack or err one cycle after acceptance", $time);
            err_cnt++;
        end

    a_no_extra_rsp: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !acc_q |-> !(bus_rsp.ack || bus_rsp.err))
        else begin
            $display("%0t: response without an accepted transfer", $time);
            err_cnt++;
        end

    a_rsp_expected: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (bus_rsp.ack || bus_rsp.err) |-> !rsp_stray)
        else begin
            $display("%0t: bus response arrived with nothing expected", $time);
            err_cnt++;
        end

    a_rsp_kind: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (bus_rsp.ack || bus_rsp.err) |-> !kind_bad)
        else begin
            $display("[FAIL] %0t bus_rsp.err got %b exp %b", $time, err_got, err_exp);
            err_cnt++;
        end

    a_rsp_data: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (bus_rsp.ack || bus_rsp.err) |-> !data_bad)
        else begin
            $display("[FAIL] %0t bus_rsp.rdata got %h exp %h", $time, data_got, data_exp);
            err_cnt++;
        end

    a_led: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        led_status == led_model)
        else begin
            $display("[FAIL] %0t led_status_o got %h exp %h", $time, led_status, led_model);
            err_cnt++;
        end

    a_irq: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        timer_irq == irq_exp_q)
        else begin
            $display("[FAIL] %0t timer_irq_o got %b exp %b", $time, timer_irq, irq_exp_q);
            err_cnt++;
        end

    a_frame: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        frame_done |-> (frame_start_ok && frame_stop_ok && !frame_stray
                        && frame_got == frame_exp))
        else begin
            $display("[FAIL] %0t uart_tx_o byte got %h exp %h start %b stop %b",
                     $time, frame_got, frame_exp, frame_start_ok, frame_stop_ok);
            err_cnt++;
        end

    // drive one request, hold it until not stalled, return at the accepting edge
    task automatic issue(input logic we, input logic [31:0] addr, input logic [31:0] wdata,
                         input logic chk, input logic exp_err, input logic use_mtime,
                         input logic [31:0] exp_data);
        int waited;
        waited = 0;
        bus_req <= '{cyc: 1'b1, stb: 1'b1, we: we, addr: addr, wdata: wdata, sel: 4'hF};
        @(negedge clk_i);
        while (bus_rsp.stall && waited < 400) begin
            waited++;
            @(negedge clk_i);
        end
        if (waited >= 400) begin
            $display("%0t: request to %h stalled too long", $time, addr);
            err_cnt++;
        end
        exp_q.push_back({exp_err, chk, use_mtime ? tick_cnt[31:0] : exp_data});
        @(posedge clk_i);
    endtask

    // release the bus and let outstanding responses drain
    task automatic drain();
        int waited;
        waited = 0;
        bus_req.cyc <= 1'b0;
        bus_req.stb <= 1'b0;
        do begin
            @(negedge clk_i);
            #1;
            waited++;
        end while (exp_q.size() != 0 && waited < 10);
        if (exp_q.size() != 0) begin
            $display("%0t: responses missing on the bus", $time);
            err_cnt++;
            exp_q.delete();
        end
        // next request starts on a rising edge
        @(posedge clk_i);
    endtask

    task automatic wait_irq(input logic level);
        int waited;
        waited = 0;
        while (timer_irq != level && waited < 200) begin
            waited++;
            @(negedge clk_i);
        end
        if (timer_irq != level) begin
            $display("%0t: timer irq did not reach %b", $time, level);
            err_cnt++;
        end
        @(posedge clk_i);
    endtask

    task automatic wait_frames(input int count);
        int waited;
        waited = 0;
        while (frame_cnt < count && waited < 1000) begin
            waited++;
            @(negedge clk_i);
        end
        if (frame_cnt < count) begin
            $display("%0t: uart frame never completed", $time);
            err_cnt++;
        end
        @(posedge clk_i);
    endtask

    initial begin
        logic [1:0]  op;
        logic [7:0]  val;
        logic [31:0] t0;
        logic [31:0] t1;
        time         acc_t;
        int          stall_cycles;
        clk_i = 1'b0;
        rst_n_i = 1'b0;
        bus_req = '0;
        seed = 62201;
        err_cnt = 0;
        led_model = '0;
        cmp_model = '1;
        frame_done = 1'b0;
        frame_cnt = 0;
        repeat (4) @(posedge clk_i);
        rst_n_i <= 1'b1;
        @(posedge clk_i);

        // led ops against the reference model
        for (int n = 0; n < 16; n++) begin
            op  = 2'($random(seed));
            val = 8'($random(seed));
            issue(1'b1, `LED_BASE + 32'(op) * 4, {24'b0, val}, 1'b0, 1'b0, 1'b0, '0);
            case (op)
                2'd0: led_model <= val;
                2'd1: led_model <= led_model | val;
                2'd2: led_model <= led_model & ~val;
                default: led_model <= led_model ^ val;
            endcase
            drain();
            issue(1'b0, `LED_BASE + 32'(op) * 4, '0, 1'b1, 1'b0, 1'b0, {24'b0, led_model});
            drain();
        end

        // timer compare and irq
        issue(1'b0, `MTIMER_BASE, '0, 1'b1, 1'b0, 1'b1, '0);
        drain();
        t0 = last_rdata;
        issue(1'b1, `MTIMER_BASE + 32'hC, 32'h0, 1'b0, 1'b0, 1'b0, '0);
        cmp_model[63:32] <= 32'h0;
        issue(1'b1, `MTIMER_BASE + 32'h8, t0 + 32'd40, 1'b0, 1'b0, 1'b0, '0);
        cmp_model[31:0] <= t0 + 32'd40;
        drain();
        wait_irq(1'b1);
        issue(1'b0, `MTIMER_BASE, '0, 1'b1, 1'b0, 1'b1, '0);
        drain();
        t0 = last_rdata;
        issue(1'b0, `MTIMER_BASE, '0, 1'b1, 1'b0, 1'b1, '0);
        drain();
        t1 = last_rdata;
        assert (t1 >= t0) else begin
            $display("[FAIL] %0t mtime got %h after %h", $time, t1, t0);
            err_cnt++;
        end
        issue(1'b1, `MTIMER_BASE + 32'hC, 32'hFFFF_FFFF, 1'b0, 1'b0, 1'b0, '0);
        cmp_model[63:32] <= 32'hFFFF_FFFF;
        drain();
        wait_irq(1'b0);

        // unmapped page answers err with zero data
        issue(1'b0, 32'h0003_0000, '0, 1'b1, 1'b1, 1'b0, '0);
        drain();

        // single uart frame with busy status around it
        val = 8'($random(seed));
        uart_exp_q.push_back(val);
        issue(1'b1, `UART_BASE, {24'b0, val}, 1'b0, 1'b0, 1'b0, '0);
        issue(1'b0, `UART_BASE + 32'h4, '0, 1'b1, 1'b0, 1'b0, 32'd1);
        drain();
        wait_frames(1);
        repeat (`UART_BAUD_DIV / 2 + 2) @(posedge clk_i);
        issue(1'b0, `UART_BASE + 32'h4, '0, 1'b1, 1'b0, 1'b0, 32'd0);
        drain();

        // second write stalls behind the first frame
        val = 8'($random(seed));
        uart_exp_q.push_back(val);
        issue(1'b1, `UART_BASE, {24'b0, val}, 1'b0, 1'b0, 1'b0, '0);
        acc_t = $time;
        val = 8'($random(seed));
        uart_exp_q.push_back(val);
        issue(1'b1, `UART_BASE, {24'b0, val}, 1'b0, 1'b0, 1'b0, '0);
        // held off for all ten bits of the first frame, 100 ns clock
        stall_cycles = int'(($time - acc_t) / 100) - 1;
        assert (stall_cycles == 10 * `UART_BAUD_DIV) else begin
            $display("[FAIL] %0t bus_rsp.stall cycles got %0d exp %0d",
                     $time, stall_cycles, 10 * `UART_BAUD_DIV);
            err_cnt++;
        end
        drain();
        wait_frames(3);

        // back to back reads, one per cycle
        issue(1'b0, `LED_BASE, '0, 1'b1, 1'b0, 1'b0, {24'b0, led_model});
        issue(1'b0, `MTIMER_BASE, '0, 1'b1, 1'b0, 1'b1, '0);
        issue(1'b0, `LED_BASE + 32'h8, '0, 1'b1, 1'b0, 1'b0, {24'b0, led_model});
        issue(1'b0, `MTIMER_BASE + 32'hC, '0, 1'b1, 1'b0, 1'b0, 32'hFFFF_FFFF);
        drain();
        repeat (4) @(negedge clk_i);

        $display("errors: %0d", err_cnt);
        if (err_cnt == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // overall run limit
    initial begin
        #(100 * 20000);
        $display("simulation ran past its time limit, errors: %0d", err_cnt);
        $display(">>> FAIL");
        $finish;
    end

endmodule : tb_platform

`default_nettype wire

/* tb.f */
+incdir+hw
hw/bus_pkg.sv
hw/platform_pkg.sv
hw/wb_decoder.sv
hw/mtimer.sv
hw/led_driver.sv
hw/uart_tx.sv
hw/yarc_platform.sv
tb/tb_platform.sv

/* run_sim.sh */
#!/usr/bin/env bash
# compile and run the platform testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_platform -f tb.f

out=$(./obj_dir/Vtb_platform)
echo "$out"

if grep -qx '>>> PASS' <<< "$out"; then
    exit 0
else
    exit 1
fi
